//--- list.f
ex_alu_pkg.sv
ex_pipe_pkg.sv
ex_alu.sv
ex_mult.sv
ex_writeback.sv
ex_stage.sv
tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - ex_alu_pkg.sv
  - ex_pipe_pkg.sv
  - ex_alu.sv
  - ex_mult.sv
  - ex_writeback.sv
  - ex_stage.sv
  - target: test
    files:
      - tb_ex_stage.sv

//--- tb_ex_stage.sv
////////////////////////////////////////////////////////////
// Self-checking testbench for the integer EX stage
// Drives random ALU, compare, multiply, CSR and LSU traffic
// plus WB back-pressure; a monitor compares every cycle at
// the falling edge against reference models
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage
  import ex_alu_pkg::*, ex_pipe_pkg::*;
();

  localparam int unsigned cycle_limit = 2000;

  logic                  clk;
  logic                  rst_n;
  logic                  alu_en;
  alu_req_t              alu_req;
  logic                  mult_en;
  mult_req_t             mult_req;
  logic                  csr_access;
  logic [xlen-1:0]       csr_rdata;
  logic                  lsu_en;
  logic                  lsu_ready_ex;
  logic                  lsu_err;
  logic [xlen-1:0]       lsu_rdata;
  logic                  regfile_alu_we;
  logic [reg_addr_w-1:0] regfile_alu_waddr;
  logic                  regfile_we;
  logic [reg_addr_w-1:0] regfile_waddr;
  logic                  branch_in_ex;
  logic                  wb_ready;
  rf_wport_t             fwd_port;
  rf_wport_t             wb_port;
  logic                  branch_decision;
  logic                  ex_ready;
  logic                  ex_valid;
  logic                  mult_multicycle;

  // Expected values with their own enables
  logic                  chk_fwd;
  rf_wport_t             exp_fwd;
  logic                  chk_hs;
  logic                  exp_ready;
  logic                  exp_valid;
  logic                  chk_br;
  logic                  exp_br;
  logic                  chk_mc;
  logic                  exp_mc;
  logic                  chk_wb;
  rf_wport_t             exp_wb;
  logic                  chk_wbwe;
  logic                  exp_wbwe;
  string                 phase;
  int unsigned           cycle_count;

  ex_stage UUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en),
    .alu_req_i           (alu_req),
    .mult_en_i           (mult_en),
    .mult_req_i          (mult_req),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .lsu_err_i           (lsu_err),
    .lsu_rdata_i         (lsu_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .branch_in_ex_i      (branch_in_ex),
    .wb_ready_i          (wb_ready),
    .fwd_port_o          (fwd_port),
    .wb_port_o           (wb_port),
    .branch_decision_o   (branch_decision),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid),
    .mult_multicycle_o   (mult_multicycle)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////
  function automatic logic cmp_model(alu_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [xlen-1:0] alu_model(alu_op_e op, logic [xlen-1:0] a,
                                                logic [xlen-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return $signed(a) >>> sh;
      ALU_SLT:  return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: return {{(xlen-1){1'b0}}, a < b};
      // Branch compares give the flag zero-extended
      default:  return {{(xlen-1){1'b0}}, cmp_model(op, a, b)};
    endcase
  endfunction

  // 64-bit product of the extended operands modulo 2^64
  function automatic logic [xlen-1:0] mult_model(mult_op_e op, logic [xlen-1:0] a,
                                                 logic [xlen-1:0] b);
    logic [2*xlen-1:0] ax;
    logic [2*xlen-1:0] bx;
    logic [2*xlen-1:0] prod;
    ax = (op == MULT_MULH || op == MULT_MULHSU) ? {{xlen{a[xlen-1]}}, a} : {{xlen{1'b0}}, a};
    bx = (op == MULT_MULH) ? {{xlen{b[xlen-1]}}, b} : {{xlen{1'b0}}, b};
    prod = ax * bx;
    return (op == MULT_MUL) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_fwd(input rf_wport_t got, input rf_wport_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s fwd port we/addr/data %b/%h/%h expected %b/%h/%h",
               $time, what, got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata);
      $display("Something failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_wb(input rf_wport_t got, input rf_wport_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s wb port we/addr/data %b/%h/%h expected %b/%h/%h",
               $time, what, got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata);
      $display("Something failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // Monitor samples mid-cycle well after the 2 ns drive
  always @(negedge clk) begin
    if (rst_n) begin
      if (chk_fwd) check_fwd(fwd_port, exp_fwd, phase);
      if (chk_hs) begin
        check_flag(ex_ready, exp_ready, {phase, " ex_ready"});
        check_flag(ex_valid, exp_valid, {phase, " ex_valid"});
      end
      if (chk_br) check_flag(branch_decision, exp_br, {phase, " branch_decision"});
      if (chk_mc) check_flag(mult_multicycle, exp_mc, {phase, " mult_multicycle"});
      if (chk_wb) check_wb(wb_port, exp_wb, phase);
      if (chk_wbwe) check_flag(wb_port.we, exp_wbwe, {phase, " wb_port.we"});
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $fatal(1, "watchdog expired");
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  // Moves to the next drive point and drops old expectations
  task automatic next_drive_slot;
    @(posedge clk);
    #2;
    chk_fwd  = 1'b0;
    chk_hs   = 1'b0;
    chk_br   = 1'b0;
    chk_mc   = 1'b0;
    chk_wb   = 1'b0;
    chk_wbwe = 1'b0;
  endtask

  task automatic idle_inputs;
    alu_en         = 1'b0;
    mult_en        = 1'b0;
    csr_access     = 1'b0;
    lsu_en         = 1'b0;
    lsu_ready_ex   = 1'b1;
    lsu_err        = 1'b0;
    regfile_alu_we = 1'b0;
    regfile_we     = 1'b0;
    branch_in_ex   = 1'b0;
    wb_ready       = 1'b1;
  endtask

  task automatic expect_fwd(input logic [xlen-1:0] data);
    chk_fwd       = 1'b1;
    exp_fwd.we    = 1'b1;
    exp_fwd.waddr = regfile_alu_waddr;
    exp_fwd.wdata = data;
  endtask

  task automatic expect_handshake(input logic rdy, input logic vld);
    chk_hs    = 1'b1;
    exp_ready = rdy;
    exp_valid = vld;
  endtask

  // Load data is passed through combinationally
  task automatic expect_wb(input logic we, input logic [reg_addr_w-1:0] addr);
    chk_wb       = 1'b1;
    exp_wb.we    = we;
    exp_wb.waddr = addr;
    exp_wb.wdata = lsu_rdata;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [reg_addr_w-1:0] cap_addr;
    logic                  err;
    int unsigned           hold;
    void'($urandom(13934));
    cycle_count       = 0;
    rst_n             = 1'b0;
    idle_inputs();
    alu_req           = '0;
    mult_req          = '0;
    csr_rdata         = '0;
    lsu_rdata         = '0;
    regfile_alu_waddr = '0;
    regfile_waddr     = '0;
    {chk_fwd, chk_hs, chk_br, chk_mc, chk_wb, chk_wbwe} = '0;
    phase = "reset";
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    phase    = "after reset";
    chk_wbwe = 1'b1;
    exp_wbwe = 1'b0;
    chk_mc   = 1'b1;
    exp_mc   = 1'b0;

    // Random ALU traffic on the forwarding port
    phase = "alu";
    repeat (100) begin
      next_drive_slot();
      idle_inputs();
      alu_en            = 1'b1;
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = $urandom;
      alu_req.op        = alu_op_e'($urandom_range(15, 0));
      alu_req.a         = $urandom;
      alu_req.b         = $urandom;
      expect_fwd(alu_model(alu_req.op, alu_req.a, alu_req.b));
      expect_handshake(1'b1, 1'b1);
    end

    // Compares with some equal operands and random branch and WB stall
    phase = "branch compare";
    repeat (80) begin
      next_drive_slot();
      idle_inputs();
      alu_en            = 1'b1;
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = $urandom;
      alu_req.op        = alu_op_e'($urandom_range(15, 10));
      alu_req.a         = $urandom;
      alu_req.b         = ($urandom_range(3, 0) == 0) ? alu_req.a : $urandom;
      branch_in_ex      = $urandom_range(1, 0);
      wb_ready          = $urandom_range(1, 0);
      expect_fwd(alu_model(alu_req.op, alu_req.a, alu_req.b));
      expect_handshake(wb_ready | branch_in_ex, wb_ready);
      chk_br = 1'b1;
      exp_br = cmp_model(alu_req.op, alu_req.a, alu_req.b);
    end

    // Single-cycle low word
    phase = "mul";
    repeat (40) begin
      next_drive_slot();
      idle_inputs();
      mult_en           = 1'b1;
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = $urandom;
      mult_req.op       = MULT_MUL;
      mult_req.a        = $urandom;
      mult_req.b        = $urandom;
      expect_fwd(mult_model(mult_req.op, mult_req.a, mult_req.b));
      expect_handshake(1'b1, 1'b1);
      chk_mc = 1'b1;
      exp_mc = 1'b0;
    end

    // High word after one stall cycle
    phase = "mulh";
    repeat (30) begin
      next_drive_slot();
      idle_inputs();
      mult_en           = 1'b1;
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = $urandom;
      mult_req.op       = mult_op_e'($urandom_range(3, 1));
      mult_req.a        = $urandom;
      mult_req.b        = $urandom;
      expect_handshake(1'b0, 1'b0);
      chk_mc = 1'b1;
      exp_mc = 1'b0;
      // Request held by ID
      next_drive_slot();
      expect_fwd(mult_model(mult_req.op, mult_req.a, mult_req.b));
      expect_handshake(1'b1, 1'b1);
      chk_mc = 1'b1;
      exp_mc = 1'b1;
    end

    // CSR read data on the forwarding port
    phase = "csr";
    repeat (20) begin
      next_drive_slot();
      idle_inputs();
      csr_access        = 1'b1;
      csr_rdata         = $urandom;
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = $urandom;
      expect_fwd(csr_rdata);
      expect_handshake(1'b1, 1'b1);
    end

    // LSU write checked on the WB port one cycle later
    phase = "lsu";
    cap_addr = '0;
    for (int i = 0; i < 30; i++) begin
      next_drive_slot();
      idle_inputs();
      lsu_en        = 1'b1;
      regfile_we    = 1'b1;
      regfile_waddr = $urandom;
      lsu_rdata     = $urandom;
      // First access clean so an address is captured
      lsu_err       = (i == 0) ? 1'b0 : ($urandom_range(3, 0) == 0);
      expect_handshake(1'b1, 1'b1);
      err = lsu_err;
      if (!lsu_err) cap_addr = regfile_waddr;
      next_drive_slot();
      idle_inputs();
      lsu_rdata = $urandom;
      expect_wb(~err, cap_addr);
      expect_handshake(1'b1, 1'b0);
    end

    // WB stall during a high-word multiply
    phase = "back-pressure";
    repeat (4) begin
      next_drive_slot();
      idle_inputs();
      lsu_en        = 1'b1;
      regfile_we    = 1'b1;
      regfile_waddr = $urandom;
      lsu_rdata     = $urandom;
      cap_addr      = regfile_waddr;
      expect_handshake(1'b1, 1'b1);
      next_drive_slot();
      idle_inputs();
      wb_ready          = 1'b0;
      mult_en           = 1'b1;
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = $urandom;
      mult_req.op       = mult_op_e'($urandom_range(3, 1));
      mult_req.a        = $urandom;
      mult_req.b        = $urandom;
      lsu_rdata         = $urandom;
      hold = $urandom_range(6, 2);
      repeat (hold) begin
        expect_handshake(1'b0, 1'b0);
        expect_wb(1'b1, cap_addr);
        next_drive_slot();
      end
      // WB frees up and the result goes out once
      wb_ready = 1'b1;
      expect_fwd(mult_model(mult_req.op, mult_req.a, mult_req.b));
      expect_handshake(1'b1, 1'b1);
      expect_wb(1'b1, cap_addr);
      chk_mc = 1'b1;
      exp_mc = 1'b1;
      next_drive_slot();
      idle_inputs();
      expect_handshake(1'b1, 1'b0);
      chk_mc   = 1'b1;
      exp_mc   = 1'b0;
      chk_wbwe = 1'b1;
      exp_wbwe = 1'b0;
    end

    next_drive_slot();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- ex_stage.sv
////////////////////////////////////////////////////////////
// Integer EX stage top level
// Connects ALU, multiplier and writeback/stall logic
// between the ID stage, the LSU and the WB stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_stage
  import ex_alu_pkg::*, ex_pipe_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // ID stage requests
  input  wire logic                  alu_en_i,
  input  wire alu_req_t              alu_req_i,
  input  wire logic                  mult_en_i,
  input  wire mult_req_t             mult_req_i,
  // CSR
  input  wire logic                  csr_access_i,
  input  wire logic [xlen-1:0]       csr_rdata_i,
  // LSU
  input  wire logic                  lsu_en_i,
  input  wire logic                  lsu_ready_ex_i,
  input  wire logic                  lsu_err_i,
  input  wire logic [xlen-1:0]       lsu_rdata_i,
  // Write port controls
  input  wire logic                  regfile_alu_we_i,
  input  wire logic [reg_addr_w-1:0] regfile_alu_waddr_i,
  input  wire logic                  regfile_we_i,
  input  wire logic [reg_addr_w-1:0] regfile_waddr_i,
  // Flow control
  input  wire logic                  branch_in_ex_i,
  input  wire logic                  wb_ready_i,
  output rf_wport_t                  fwd_port_o,
  output rf_wport_t                  wb_port_o,
  output logic                       branch_decision_o,
  output logic                       ex_ready_o,
  output logic                       ex_valid_o,
  output logic                       mult_multicycle_o
);

  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] mult_result;
  logic            mult_ready;

  // Comparator output is the branch decision
  ex_alu u_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Stalls through ex_ready_o on high-word ops
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback u_writeback (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .mult_ready_i        (mult_ready),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .lsu_err_i           (lsu_err_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .wb_ready_i          (wb_ready_i),
    .fwd_port_o          (fwd_port_o),
    .wb_port_o           (wb_port_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

`default_nettype wire

//--- ex_writeback.sv
////////////////////////////////////////////////////////////
// EX stage write ports and stall control
// Forwarding port picks CSR, multiplier or ALU data in the
// same cycle; the EX/WB register feeds the load/store port
// Ready goes to ID, valid goes to WB
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_writeback
  import ex_alu_pkg::*, ex_pipe_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // Unit enables
  input  wire logic                  alu_en_i,
  input  wire logic                  mult_en_i,
  input  wire logic                  csr_access_i,
  input  wire logic                  lsu_en_i,
  // Results
  input  wire logic [xlen-1:0]       alu_result_i,
  input  wire logic [xlen-1:0]       mult_result_i,
  input  wire logic                  mult_ready_i,
  input  wire logic [xlen-1:0]       csr_rdata_i,
  // Forwarding port controls
  input  wire logic                  regfile_alu_we_i,
  input  wire logic [reg_addr_w-1:0] regfile_alu_waddr_i,
  // WB port controls
  input  wire logic                  regfile_we_i,
  input  wire logic [reg_addr_w-1:0] regfile_waddr_i,
  // LSU
  input  wire logic                  lsu_ready_ex_i,
  input  wire logic                  lsu_err_i,
  input  wire logic [xlen-1:0]       lsu_rdata_i,
  // Flow control
  input  wire logic                  branch_in_ex_i,
  input  wire logic                  wb_ready_i,
  output rf_wport_t                  fwd_port_o,
  output rf_wport_t                  wb_port_o,
  output logic                       ex_ready_o,
  output logic                       ex_valid_o
);

  logic                  units_ready;
  logic                  lsu_we_q;
  logic [reg_addr_w-1:0] lsu_waddr_q;
  logic                  lsu_we_d;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////
  always_comb begin
    fwd_port_o.waddr = regfile_alu_waddr_i;
    // No write while a high-word multiply is in flight
    fwd_port_o.we    = regfile_alu_we_i & mult_ready_i;
    // Later assignments win so CSR has top priority
    fwd_port_o.wdata = '0;
    if (alu_en_i) begin
      fwd_port_o.wdata = alu_result_i;
    end
    if (mult_en_i) begin
      fwd_port_o.wdata = mult_result_i;
    end
    if (csr_access_i) begin
      fwd_port_o.wdata = csr_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stall control
  ////////////////////////////////////////////////////////////
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve in EX, so they never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid is independent of ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////
  // Faulting loads never write back
  assign lsu_we_d = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_q <= lsu_we_d;
    end else if (wb_ready_i) begin
      // Bubble flushes the old write
      lsu_we_q <= 1'b0;
    end
  end

  // Address only follows enabled writes
  always_ff @(posedge clk) begin
    if (ex_valid_o && lsu_we_d) begin
      lsu_waddr_q <= regfile_waddr_i;
    end
  end

  // Load data arrives straight from the LSU
  assign wb_port_o.we    = lsu_we_q;
  assign wb_port_o.waddr = lsu_waddr_q;
  assign wb_port_o.wdata = lsu_rdata_i;

  // Decoder issues to one result unit at a time
  a_single_unit : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_i, mult_en_i, csr_access_i})
  ) else $error("more than one EX unit enabled");

endmodule

`default_nettype wire

//--- ex_mult.sv
////////////////////////////////////////////////////////////
// Integer multiplier of the EX stage
// MUL returns the low word in the same cycle; MULH, MULHSU
// and MULHU register the full product and return the high
// word one cycle later, held until ex_ready_i
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_mult
  import ex_alu_pkg::*, ex_pipe_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       enable_i,
  input  wire mult_req_t  mult_req_i,
  input  wire logic       ex_ready_i,
  output logic [xlen-1:0] result_o,
  output logic            ready_o,
  output logic            multicycle_o
);

  // Idle computes MUL and launches high-word ops
  typedef enum logic {
    MULT_IDLE = 1'b0,
    MULT_DONE = 1'b1
  } mult_state_e;

  mult_state_e         state_q;
  mult_state_e         state_d;
  logic                a_signed;
  logic                b_signed;
  logic [xlen:0]       op_a_ext;
  logic [xlen:0]       op_b_ext;
  logic [2*xlen-1:0]   prod_full;
  logic [2*xlen-1:0]   prod_q;
  logic                start_high;

  ////////////////////////////////////////////////////////////
  // Operand extension and product
  ////////////////////////////////////////////////////////////
  // MULH signs both, MULHSU only a, MULHU neither
  assign a_signed = (mult_req_i.op == MULT_MULH) || (mult_req_i.op == MULT_MULHSU);
  assign b_signed = (mult_req_i.op == MULT_MULH);

  assign op_a_ext = {a_signed & mult_req_i.a[xlen-1], mult_req_i.a};
  assign op_b_ext = {b_signed & mult_req_i.b[xlen-1], mult_req_i.b};

  // Low 64 bits of the 33x33 signed product are exact in all modes
  assign prod_full = $signed(op_a_ext) * $signed(op_b_ext);

  // High-word op seen while idle
  assign start_high = (state_q == MULT_IDLE) && enable_i && (mult_req_i.op != MULT_MUL);

  // Full product latched at the start of a high-word op
  always_ff @(posedge clk) begin
    if (start_high) begin
      prod_q <= prod_full;
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: begin
        if (start_high) begin
          state_d = MULT_DONE;
        end
      end
      // Hold the high word under back-pressure
      MULT_DONE: begin
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Outputs
  assign result_o     = (state_q == MULT_DONE) ? prod_q[2*xlen-1:xlen] : prod_full[xlen-1:0];
  assign ready_o      = ~start_high;
  assign multicycle_o = (state_q == MULT_DONE);

  // ID must hold the request through the stall cycle
  a_mult_operands_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (enable_i && !ready_o) |=> (enable_i && $stable(mult_req_i))
  ) else $error("multiplier request changed during high-word stall");

endmodule

`default_nettype wire

//--- ex_alu.sv
////////////////////////////////////////////////////////////
// Single-cycle integer ALU with branch comparator
// Purely combinational; result_o feeds the forwarding mux
// and cmp_result_o is the branch decision
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_alu
  import ex_alu_pkg::*, ex_pipe_pkg::*;
(
  input  wire alu_req_t   alu_req_i,
  output logic [xlen-1:0] result_o,
  output logic            cmp_result_o
);

  localparam int unsigned shamt_w = $clog2(xlen);

  logic [xlen:0]        diff;
  logic [shamt_w-1:0]   shamt;
  logic                 eq;
  logic                 lt_u;
  logic                 lt_s;

  // Shared subtractor with the borrow in the top bit
  assign diff  = {1'b0, alu_req_i.a} - {1'b0, alu_req_i.b};
  assign shamt = alu_req_i.b[shamt_w-1:0];

  // Compare flags from the subtractor
  assign eq   = (diff[xlen-1:0] == '0);
  assign lt_u = diff[xlen];
  // With differing signs a is less when negative
  assign lt_s = (alu_req_i.a[xlen-1] ^ alu_req_i.b[xlen-1]) ?
                alu_req_i.a[xlen-1] : diff[xlen-1];

  ////////////////////////////////////////////////////////////
  // Branch comparator
  ////////////////////////////////////////////////////////////
  always_comb begin
    cmp_result_o = 1'b0;
    case (alu_req_i.op)
      ALU_EQ:  cmp_result_o = eq;
      ALU_NE:  cmp_result_o = ~eq;
      ALU_LT:  cmp_result_o = lt_s;
      ALU_GE:  cmp_result_o = ~lt_s;
      ALU_LTU: cmp_result_o = lt_u;
      ALU_GEU: cmp_result_o = ~lt_u;
      default: cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////
  always_comb begin
    result_o = '0;
    case (alu_req_i.op)
      ALU_ADD:  result_o = alu_req_i.a + alu_req_i.b;
      ALU_SUB:  result_o = diff[xlen-1:0];
      ALU_XOR:  result_o = alu_req_i.a ^ alu_req_i.b;
      ALU_OR:   result_o = alu_req_i.a | alu_req_i.b;
      ALU_AND:  result_o = alu_req_i.a & alu_req_i.b;
      // Shifts use the low five bits of b only
      ALU_SLL:  result_o = alu_req_i.a << shamt;
      ALU_SRL:  result_o = alu_req_i.a >> shamt;
      ALU_SRA:  result_o = $signed(alu_req_i.a) >>> shamt;
      ALU_SLT:  result_o = {{(xlen-1){1'b0}}, lt_s};
      ALU_SLTU: result_o = {{(xlen-1){1'b0}}, lt_u};
      // Comparisons return the flag zero-extended
      ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU: begin
        result_o = {{(xlen-1){1'b0}}, cmp_result_o};
      end
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- ex_pipe_pkg.sv
////////////////////////////////////////////////////////////
// Request and write-port bundles passed between the ID,
// EX and WB stages
// Both register-file write ports share rf_wport_t
////////////////////////////////////////////////////////////

`default_nettype none

package ex_pipe_pkg;

  import ex_alu_pkg::*;

  // Register-file write address including the FP bank bit
  localparam int unsigned reg_addr_w = 6;

  // 68-bit ALU request from ID
  typedef struct packed {
    alu_op_e         op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } alu_req_t;

  // 66-bit multiplier request from ID
  typedef struct packed {
    mult_op_e        op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } mult_req_t;

  // One 39-bit register-file write port
  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
  } rf_wport_t;

endpackage

`default_nettype wire

//--- ex_alu_pkg.sv
////////////////////////////////////////////////////////////
// Operator encodings and data widths of the EX stage
// Import into the ALU, the multiplier and anything that
// builds or checks their requests
////////////////////////////////////////////////////////////

`default_nettype none

package ex_alu_pkg;

  // RV32 datapath width
  localparam int unsigned xlen = 32;

  // Encoded operator widths
  localparam int unsigned alu_op_w  = 4;
  localparam int unsigned mult_op_w = 2;

  // ALU operators with the comparisons in the upper half
  typedef enum logic [alu_op_w-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators where only MUL is single cycle
  typedef enum logic [mult_op_w-1:0] {
    MULT_MUL    = 2'd0,
    MULT_MULH   = 2'd1,
    MULT_MULHSU = 2'd2,
    MULT_MULHU  = 2'd3
  } mult_op_e;

endpackage

`default_nettype wire
